//--- vlog.f
common/tracker_pkg.sv
rtl/tracker_fsm.sv
rtl/capture_counter.sv
error_tracker/history_pipe.sv
error_tracker/capture_ram.sv
rtl/error_tracker_top.sv
sim/tb_clk_gen.sv
sim/error_tracker_chk.sv
sim/tb_error_tracker.sv

//--- Bender.yml
package:
  name: error_tracker

sources:
  - common/tracker_pkg.sv
  - rtl/tracker_fsm.sv
  - rtl/capture_counter.sv
  - error_tracker/history_pipe.sv
  - error_tracker/capture_ram.sv
  - rtl/error_tracker_top.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/error_tracker_chk.sv
      - sim/tb_error_tracker.sv

//--- sim/tb_error_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module tb_error_tracker;

    localparam int lanes     = 4;
    localparam int err_w     = 8;
    localparam int addr_w    = 3;
    localparam int depth     = 1 << addr_w;
    localparam int lane_w    = err_w + 4;
    localparam int slot_w    = lanes * lane_w;
    localparam int entry_w   = 3 * slot_w;
    localparam int cap_limit = 200;
    localparam int total_cycles = 4 + 12 + 2 * cap_limit + 20 + 3 * depth + 12;
    localparam longint timeout_ns = 50 * total_cycles * 10;

    logic                   clk;
    logic                   arst_n;
    logic [lanes-1:0]       prbs_flags = '0;
    logic [lanes*err_w-1:0] est_error = '0;
    logic [lanes-1:0]       sliced_bits = '0;
    logic [2*lanes-1:0]     sd_flags = '0;
    logic                   arm = 1'b0;
    logic [addr_w-1:0]      rd_addr = '0;
    logic [addr_w:0]        entry_count;
    logic                   full;
    logic [entry_w-1:0]     rd_data;

    // model of the last cycles and of the capture memory.
    logic [entry_w-1:0] exp_mem [depth];
    logic [lanes-1:0]   prev_prbs = '0;
    logic [slot_w-1:0]  w_m1 = '0;
    logic [slot_w-1:0]  w_m2 = '0;
    bit                 m_capture = 1'b0;
    int                 m_count = 0;
    logic [15:0]        lfsr_q = 16'd40;

    tb_clk_gen #(.period_ns(10), .reset_cycles(4)) u_clk_gen (.clk_o(clk), .arst_n_o(arst_n));

    error_tracker_top #(
        .width          (lanes),
        .error_bitwidth (err_w),
        .addrwidth      (addr_w)
    ) dut (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .prbs_flags_i   (prbs_flags),
        .est_error_i    (est_error),
        .sliced_bits_i  (sliced_bits),
        .sd_flags_i     (sd_flags),
        .arm_i          (arm),
        .rd_addr_i      (rd_addr),
        .entry_count_o  (entry_count),
        .full_o         (full),
        .rd_data_o      (rd_data)
    );

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------

    // x^16 + x^14 + x^13 + x^11.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // lane fields from prbs flag down to error.
    function automatic logic [slot_w-1:0] cycle_word(input logic [lanes-1:0] prbs,
            input logic [lanes-1:0] bits, input logic [2*lanes-1:0] sd,
            input logic [lanes*err_w-1:0] err);
        logic [slot_w-1:0] w;
        for (int ln = 0; ln < lanes; ln++) begin
            w[ln*lane_w +: lane_w] = {prbs[ln], bits[ln], sd[2*ln +: 2], err[ln*err_w +: err_w]};
        end
        return w;
    endfunction

    task automatic check_value(input string test_name, input logic [entry_w-1:0] expected,
            input logic [entry_w-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", test_name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch in %s", test_name);
        end
    endtask

    // drives one cycle and steps the model through it.
    task automatic drive_cycle(input logic [lanes-1:0] prbs, input logic [lanes-1:0] bits,
            input logic [2*lanes-1:0] sd, input logic [lanes*err_w-1:0] err, input logic arm_v);
        logic [slot_w-1:0] w_now;
        @(posedge clk);
        #1;
        prbs_flags  = prbs;
        sliced_bits = bits;
        sd_flags    = sd;
        est_error   = err;
        arm         = arm_v;
        w_now = cycle_word(prbs, bits, sd, err);
        if (|prev_prbs && m_capture && !arm_v) begin
            exp_mem[m_count] = {w_now, w_m1, w_m2};
            m_count++;
            if (m_count == depth) begin
                m_capture = 1'b0;
            end
        end
        if (arm_v) begin
            m_capture = 1'b1;
            m_count   = 0;
        end
        prev_prbs = prbs;
        w_m2      = w_m1;
        w_m1      = w_now;
    endtask

    task automatic drive_idle(input int n);
        repeat (n) drive_cycle('0, '0, '0, '0, 1'b0);
    endtask

    task automatic drive_random(input bit dense);
        logic [lanes-1:0]       prbs;
        logic [lanes-1:0]       bits;
        logic [2*lanes-1:0]     sd;
        logic [lanes*err_w-1:0] err;
        bits = lanes'(take_bits(lanes));
        sd   = (2 * lanes)'(take_bits(2 * lanes));
        err  = (lanes * err_w)'(take_bits(lanes * err_w));
        if (dense) begin
            prbs = lanes'(take_bits(lanes)) | lanes'(1);
        end else begin
            prbs = (take_bits(2) == 0) ? lanes'(take_bits(lanes)) : '0;
        end
        drive_cycle(prbs, bits, sd, err, 1'b0);
    endtask

    task automatic read_back(input string test_name, input int n);
        for (int a = 0; a < n; a++) begin
            rd_addr = addr_w'(a);
            drive_idle(1);
            check_value(test_name, exp_mem[a], rd_data);
        end
    endtask

    // ------------------------------------------------------------
    // sequence
    // ------------------------------------------------------------

    initial begin
        int guard;
        @(posedge arst_n);
        repeat (8) drive_random(1'b1);
        drive_idle(3);
        check_value("idle_drop", '0, entry_count);

        drive_cycle('0, '0, '0, '0, 1'b1);
        guard = 0;
        while (m_count < depth && guard < cap_limit) begin
            drive_random(1'b0);
            guard++;
        end
        // flags while full are dropped.
        repeat (10) drive_random(1'b1);
        drive_idle(3);
        check_value("fill_count", depth, entry_count);
        check_value("fill_full", 1, full);
        read_back("window_content", depth);

        drive_cycle('0, '0, '0, '0, 1'b1);
        drive_idle(1);
        check_value("rearm_clear", '0, {full, entry_count});
        guard = 0;
        while (m_count < 3 && guard < cap_limit) begin
            drive_random(1'b0);
            guard++;
        end
        drive_idle(3);
        check_value("rearm_count", m_count, entry_count);
        read_back("rearm_window", m_count);
        drive_idle(2);

        if (dut.u_chk.fail_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Simulation FAILED");
            $fatal(1, "assertion failures reported by the checker");
        end
    end

    always @(negedge clk) begin
        if (dut.u_chk.fail_count != 0) begin
            $display("Simulation FAILED");
            $fatal(1, "assertion failure in error_tracker_chk");
        end
    end

    initial begin
        #(timeout_ns);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired after %0d ns without finishing", timeout_ns);
    end

endmodule : tb_error_tracker

`default_nettype wire

//--- sim/error_tracker_chk.sv
`timescale 1ns/10ps
`default_nettype none

module error_tracker_chk #(
    parameter int width     = 16,
    parameter int addrwidth = 10
) (
    input logic               clk,
    input logic               arst_n_i,
    input logic               arm_i,
    input logic [width-1:0]   prbs_flags_i,
    input logic [addrwidth:0] count_i,
    input logic               full_i
);

    localparam int depth = 1 << addrwidth;

    int   fail_count = 0;
    logic armed_q;

    // set by the first arm and cleared only by reset.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            armed_q <= 1'b0;
        end else if (arm_i) begin
            armed_q <= 1'b1;
        end
    end

    // ----------------------------------------------------------
    // port properties
    // ----------------------------------------------------------

    reset_state_a: assert property (@(posedge clk)
        !armed_q |-> (count_i == '0 && !full_i))
        else begin
            fail_count++;
            $error("count or full set before the first arm");
        end

    idle_drop_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        (!armed_q && !arm_i && |prbs_flags_i) |-> ##2 (count_i == '0))
        else begin
            fail_count++;
            $error("flag captured while idle");
        end

    count_step_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        (|prbs_flags_i) ##1 (armed_q && !full_i && !arm_i)
        |=> (count_i == $past(count_i) + 1'b1))
        else begin
            fail_count++;
            $error("entry count did not step after a flag");
        end

    full_at_depth_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        (count_i == depth) |-> full_i)
        else begin
            fail_count++;
            $error("memory holds all entries but full is low");
        end

    full_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        (full_i && !arm_i) |=> (full_i && $stable(count_i)))
        else begin
            fail_count++;
            $error("full state left or count moved without arm");
        end

    rearm_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        arm_i |=> (!full_i && count_i == '0))
        else begin
            fail_count++;
            $error("arm did not clear count and full");
        end

endmodule : error_tracker_chk

bind error_tracker_top error_tracker_chk #(
    .width     (width),
    .addrwidth (addrwidth)
) u_chk (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .arm_i        (arm_i),
    .prbs_flags_i (prbs_flags_i),
    .count_i      (entry_count_o),
    .full_i       (full_o)
);

`default_nettype wire

//--- sim/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
    parameter int period_ns    = 10,
    parameter int reset_cycles = 4
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(period_ns / 2) clk_o = ~clk_o;
    end

    // release just after an edge.
    initial begin
        arst_n_o = 1'b0;
        repeat (reset_cycles) @(posedge clk_o);
        #1;
        arst_n_o = 1'b1;
    end

endmodule : tb_clk_gen

`default_nettype wire

//--- rtl/error_tracker_top.sv
`timescale 1ns/10ps
`default_nettype none

module error_tracker_top
    import tracker_pkg::*;
#(
    parameter int width          = 16,
    parameter int error_bitwidth = 8,
    parameter int addrwidth      = 10,
    localparam int entry_w       = slot_count * width * (error_bitwidth + 4)
) (
    input  logic                                 clk,
    input  logic                                 arst_n_i,

    // lane data, one entry per lane.
    input  logic     [width-1:0]                 prbs_flags_i,
    input  logic     [width-1:0][error_bitwidth-1:0] est_error_i,
    input  logic     [width-1:0]                 sliced_bits_i,
    input  sd_flag_t [width-1:0]                 sd_flags_i,

    // debug access.
    input  logic                                 arm_i,
    input  logic     [addrwidth-1:0]             rd_addr_i,
    output logic     [addrwidth:0]               entry_count_o,
    output logic                                 full_o,
    output logic     [entry_w-1:0]               rd_data_o
);

    logic                 trigger;
    logic [entry_w-1:0]   window;
    logic                 wr_en;
    logic                 clear;
    logic                 last;
    logic [addrwidth-1:0] wr_addr;

    // ----------------------------------------------------------
    // datapath
    // ----------------------------------------------------------

    history_pipe #(
        .width          (width),
        .error_bitwidth (error_bitwidth)
    ) u_history_pipe (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .prbs_flags_i   (prbs_flags_i),
        .est_error_i    (est_error_i),
        .sliced_bits_i  (sliced_bits_i),
        .sd_flags_i     (sd_flags_i),
        .trigger_o      (trigger),
        .window_o       (window)
    );

    capture_ram #(
        .width          (width),
        .error_bitwidth (error_bitwidth),
        .addrwidth      (addrwidth)
    ) u_capture_ram (
        .clk            (clk),
        .wr_en_i        (wr_en),
        .wr_addr_i      (wr_addr),
        .wr_data_i      (window),
        .rd_addr_i      (rd_addr_i),
        .rd_data_o      (rd_data_o)
    );

    // ----------------------------------------------------------
    // control
    // ----------------------------------------------------------

    tracker_fsm u_tracker_fsm (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .arm_i          (arm_i),
        .trigger_i      (trigger),
        .last_i         (last),
        .wr_en_o        (wr_en),
        .clear_o        (clear),
        .full_o         (full_o)
    );

    capture_counter #(
        .addrwidth      (addrwidth)
    ) u_capture_counter (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .clear_i        (clear),
        .inc_i          (wr_en),
        .wr_addr_o      (wr_addr),
        .entry_count_o  (entry_count_o),
        .last_o         (last)
    );

endmodule : error_tracker_top

`default_nettype wire

//--- error_tracker/capture_ram.sv
`timescale 1ns/10ps
`default_nettype none

module capture_ram
    import tracker_pkg::*;
#(
    parameter int width          = 16,
    parameter int error_bitwidth = 8,
    parameter int addrwidth      = 10,
    localparam int entry_w       = slot_count * width * (error_bitwidth + 4),
    localparam int depth         = 2 ** addrwidth
) (
    input  logic                 clk,

    input  logic                 wr_en_i,
    input  logic [addrwidth-1:0] wr_addr_i,
    input  logic [entry_w-1:0]   wr_data_i,

    input  logic [addrwidth-1:0] rd_addr_i,
    output logic [entry_w-1:0]   rd_data_o
);

    logic [entry_w-1:0] mem [depth];

    // write port.
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // read port, one cycle latency.
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule : capture_ram

`default_nettype wire

//--- error_tracker/history_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module history_pipe
    import tracker_pkg::*;
#(
    parameter int width          = 16,
    parameter int error_bitwidth = 8,
    localparam int lane_w        = error_bitwidth + 4,
    localparam int entry_w       = slot_count * width * lane_w
) (
    input  logic                                 clk,
    input  logic                                 arst_n_i,

    input  logic     [width-1:0]                 prbs_flags_i,
    input  logic     [width-1:0][error_bitwidth-1:0] est_error_i,
    input  logic     [width-1:0]                 sliced_bits_i,
    input  sd_flag_t [width-1:0]                 sd_flags_i,

    output logic                                 trigger_o,
    output logic     [entry_w-1:0]               window_o
);

    logic     [width-1:0]                     prbs_q1;
    logic     [width-1:0]                     prbs_q2;
    logic     [width-1:0]                     bits_q1;
    logic     [width-1:0]                     bits_q2;
    sd_flag_t [width-1:0]                     sd_q1;
    sd_flag_t [width-1:0]                     sd_q2;
    logic     [width-1:0][error_bitwidth-1:0] err_q1;
    logic     [width-1:0][error_bitwidth-1:0] err_q2;

    logic [slot_count-1:0][width-1:0][lane_w-1:0] slots;

    // ----------------------------------------------------------
    // two-deep history
    // ----------------------------------------------------------

    // flags drive the trigger.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prbs_q1 <= '0;
            prbs_q2 <= '0;
        end else begin
            prbs_q1 <= prbs_flags_i;
            prbs_q2 <= prbs_q1;
        end
    end

    always_ff @(posedge clk) begin
        bits_q1 <= sliced_bits_i;
        bits_q2 <= bits_q1;
        sd_q1   <= sd_flags_i;
        sd_q2   <= sd_q1;
        err_q1  <= est_error_i;
        err_q2  <= err_q1;
    end

    // mismatch in the middle cycle.
    assign trigger_o = |prbs_q1;

    // ----------------------------------------------------------
    // flatten
    // ----------------------------------------------------------

    // oldest cycle in slot 0, lane 0 lowest in each slot.
    always_comb begin
        for (int ln = 0; ln < width; ln++) begin
            slots[0][ln] = {prbs_q2[ln], bits_q2[ln], sd_q2[ln], err_q2[ln]};
            slots[1][ln] = {prbs_q1[ln], bits_q1[ln], sd_q1[ln], err_q1[ln]};
            slots[2][ln] = {prbs_flags_i[ln], sliced_bits_i[ln], sd_flags_i[ln],
                            est_error_i[ln]};
        end
    end

    assign window_o = slots;

endmodule : history_pipe

`default_nettype wire

//--- rtl/capture_counter.sv
`timescale 1ns/10ps
`default_nettype none

module capture_counter #(
    parameter int addrwidth = 10
) (
    input  logic                 clk,
    input  logic                 arst_n_i,

    input  logic                 clear_i,
    input  logic                 inc_i,

    output logic [addrwidth-1:0] wr_addr_o,
    output logic [addrwidth:0]   entry_count_o,
    output logic                 last_o
);

    logic [addrwidth:0] count_q;

    // clear wins over a write in the same cycle.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;
        end else if (inc_i) begin
            count_q <= count_q + 1'b1;
        end
    end

    // next free slot.
    assign wr_addr_o     = count_q[addrwidth-1:0];
    assign entry_count_o = count_q;

    // Flags the top address, not the full count.
    assign last_o = (wr_addr_o == {addrwidth{1'b1}});

endmodule : capture_counter

`default_nettype wire

//--- rtl/tracker_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module tracker_fsm
    import tracker_pkg::*;
(
    input  logic clk,
    input  logic arst_n_i,

    input  logic arm_i,
    input  logic trigger_i,
    input  logic last_i,

    output logic wr_en_o,
    output logic clear_o,
    output logic full_o
);

    tracker_state_t state_q;
    tracker_state_t state_d;

    // ----------------------------------------------------------
    // next state
    // ----------------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            TRK_CAPTURE: begin
                // the write into the final address fills the memory.
                if (wr_en_o && last_i) begin
                    state_d = TRK_FULL;
                end
            end
            default: begin
                state_d = state_q;
            end
        endcase
        // arm restarts from any state.
        if (arm_i) begin
            state_d = TRK_CAPTURE;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= TRK_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ----------------------------------------------------------
    // outputs
    // ----------------------------------------------------------

    // no write in the arm cycle, the counter is being cleared.
    assign wr_en_o = trigger_i && (state_q == TRK_CAPTURE) && !arm_i;
    assign clear_o = arm_i;
    assign full_o  = (state_q == TRK_FULL);

endmodule : tracker_fsm

`default_nettype wire

//--- common/tracker_pkg.sv
`default_nettype none

package tracker_pkg;

    // ----------------------------------------------------------
    // window geometry
    // ----------------------------------------------------------

    // cycles held in one captured window.
    localparam int slot_count = 3;

    // sign/data flags of one lane.
    typedef logic [1:0] sd_flag_t;

    // ----------------------------------------------------------
    // tracker control
    // ----------------------------------------------------------

    typedef enum logic [1:0] {
        TRK_IDLE,
        TRK_CAPTURE,
        TRK_FULL
    } tracker_state_t;

endpackage : tracker_pkg

`default_nettype wire
